// File: logic/b2s_pkg.sv
`default_nettype none

package b2s_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int id_w = 4;
  localparam int len_w = 8; // beats in a burst are len + 1

  localparam int beat_bytes = 4;

  localparam int fifo_depth = 8;
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

  // AXI read address payload
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [len_w-1:0] len;
    logic [id_w-1:0] id;
  } ar_cmd_t;

  // label of one issued beat, kept until its data comes back
  typedef struct packed {
    logic [id_w-1:0] id;
    logic last;
  } beat_tag_t;

  // AXI R payload
  typedef struct packed {
    logic [data_w-1:0] data;
    logic [id_w-1:0] id;
    logic last;
  } r_beat_t;

endpackage

`default_nettype wire

// File: logic/beat_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module beat_fifo #(
  parameter type payload_t = logic
) (
  input logic clk,
  input logic reset,
  input logic push,
  input payload_t din,
  input logic pop,
  output payload_t dout,
  output logic empty,
  output logic full,
  output logic [b2s_pkg::fifo_cnt_w-1:0] count
);

  payload_t mem [b2s_pkg::fifo_depth];

  logic [b2s_pkg::fifo_ptr_w-1:0] wr_ptr;
  logic [b2s_pkg::fifo_ptr_w-1:0] rd_ptr;
  logic do_push;
  logic do_pop;

  assign do_push = push && !full;
  assign do_pop = pop && !empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == b2s_pkg::fifo_ptr_w'(b2s_pkg::fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == b2s_pkg::fifo_ptr_w'(b2s_pkg::fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  assign dout = mem[rd_ptr]; // show-ahead head entry
  assign empty = (count == '0);
  assign full = (count == b2s_pkg::fifo_cnt_w'(b2s_pkg::fifo_depth));

endmodule

`default_nettype wire

// File: logic/rd_cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module rd_cmd_fsm (
  input logic clk,
  input logic reset,
  input logic s_arvalid,
  output logic s_arready,
  input logic m_arready,
  output logic m_arvalid,
  output logic next,
  input logic next_pending,
  input logic data_ready,
  output logic a_push,
  output logic r_push
);

  typedef enum logic [1:0] {
    sm_idle = 2'b00,
    sm_cmd_en = 2'b01,
    sm_cmd_accepted = 2'b10,
    sm_done = 2'b11
  } state_t;

  state_t state;
  state_t next_state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sm_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      sm_idle: begin
        if (s_arvalid && data_ready) begin
          next_state = sm_cmd_en;
        end
      end
      sm_cmd_en: begin
        if (m_arready && !next_pending) begin
          next_state = sm_done; // last beat of the burst has gone out
        end else if (m_arready && !data_ready) begin
          next_state = sm_cmd_accepted; // no slot left for the following beat
        end
      end
      sm_cmd_accepted: begin
        if (data_ready) begin
          next_state = sm_cmd_en;
        end
      end
      sm_done: begin
        next_state = sm_idle;
      end
      default: begin
        next_state = sm_idle;
      end
    endcase
  end

  assign m_arvalid = (state == sm_cmd_en);
  assign next = m_arready && (state == sm_cmd_en);
  assign r_push = next; // tag is captured on the same handshake that issues the beat
  assign a_push = (state == sm_idle);
  assign s_arready = (state == sm_done);

endmodule

`default_nettype wire

// File: logic/burst_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module burst_addr_gen (
  input logic clk,
  input logic reset,
  input logic load,
  input b2s_pkg::ar_cmd_t s_ar,
  input logic next,
  output logic [b2s_pkg::addr_w-1:0] m_araddr,
  output logic next_pending,
  output b2s_pkg::beat_tag_t tag
);

  logic [b2s_pkg::addr_w-1:0] addr_q;
  logic [b2s_pkg::id_w-1:0] id_q;
  logic [b2s_pkg::len_w-1:0] beats_left; // beats still to issue after the current one

  always_ff @(posedge clk) begin
    if (reset) begin
      beats_left <= '0;
    end else if (load) begin
      beats_left <= s_ar.len;
    end else if (next && next_pending) begin
      beats_left <= beats_left - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      addr_q <= s_ar.addr;
      id_q <= s_ar.id;
    end else if (next) begin
      addr_q <= addr_q + b2s_pkg::addr_w'(b2s_pkg::beat_bytes); // INCR only
    end
  end

  assign next_pending = (beats_left != '0);
  assign m_araddr = addr_q;

  assign tag.id = id_q;
  assign tag.last = !next_pending;

endmodule

`default_nettype wire

// File: logic/rd_resp_path.sv
`timescale 1ns/1ps
`default_nettype none

module rd_resp_path (
  input logic clk,
  input logic reset,
  input logic r_push,
  input b2s_pkg::beat_tag_t tag,
  input logic m_rvalid,
  input logic [b2s_pkg::data_w-1:0] m_rdata,
  output logic data_ready,
  output logic s_rvalid,
  input logic s_rready,
  output b2s_pkg::r_beat_t s_r
);

  b2s_pkg::beat_tag_t tag_head;
  logic [b2s_pkg::data_w-1:0] data_head;
  logic [b2s_pkg::fifo_cnt_w-1:0] tag_count;
  logic tag_full;
  logic data_empty;
  logic r_pop;

  assign r_pop = s_rvalid && s_rready;

  beat_fifo #(
    .payload_t(b2s_pkg::beat_tag_t)
  ) tag_fifo_i (
    .clk(clk),
    .reset(reset),
    .push(r_push),
    .din(tag),
    .pop(r_pop),
    .dout(tag_head),
    .empty(),
    .full(tag_full),
    .count(tag_count)
  );

  // data count never passes tag count, so this one cannot overflow
  beat_fifo #(
    .payload_t(logic [b2s_pkg::data_w-1:0])
  ) data_fifo_i (
    .clk(clk),
    .reset(reset),
    .push(m_rvalid),
    .din(m_rdata),
    .pop(r_pop),
    .dout(data_head),
    .empty(data_empty),
    .full(),
    .count()
  );

  // a tag being pushed this cycle already holds its slot, so the free entry must be another one
  assign data_ready = !tag_full &&
    !(r_push && (tag_count == b2s_pkg::fifo_cnt_w'(b2s_pkg::fifo_depth - 1)));

  assign s_rvalid = !data_empty;
  assign s_r.data = data_head;
  assign s_r.id = tag_head.id;
  assign s_r.last = tag_head.last;

endmodule

`default_nettype wire

// File: logic/axi_b2s_rd.sv
`timescale 1ns/1ps
`default_nettype none

module axi_b2s_rd (
  input logic clk,
  input logic reset,
  input logic s_arvalid,
  output logic s_arready,
  input b2s_pkg::ar_cmd_t s_ar,
  output logic m_arvalid,
  input logic m_arready,
  output logic [b2s_pkg::addr_w-1:0] m_araddr,
  input logic m_rvalid,
  input logic [b2s_pkg::data_w-1:0] m_rdata,
  output logic s_rvalid,
  input logic s_rready,
  output b2s_pkg::r_beat_t s_r
);

  logic a_push;
  logic next;
  logic next_pending;
  logic data_ready;
  logic r_push;
  b2s_pkg::beat_tag_t tag;

  rd_cmd_fsm rd_cmd_fsm_i (
    .clk(clk),
    .reset(reset),
    .s_arvalid(s_arvalid),
    .s_arready(s_arready),
    .m_arready(m_arready),
    .m_arvalid(m_arvalid),
    .next(next),
    .next_pending(next_pending),
    .data_ready(data_ready),
    .a_push(a_push),
    .r_push(r_push)
  );

  burst_addr_gen burst_addr_gen_i (
    .clk(clk),
    .reset(reset),
    .load(a_push),
    .s_ar(s_ar),
    .next(next),
    .m_araddr(m_araddr),
    .next_pending(next_pending),
    .tag(tag)
  );

  rd_resp_path rd_resp_path_i (
    .clk(clk),
    .reset(reset),
    .r_push(r_push),
    .tag(tag),
    .m_rvalid(m_rvalid),
    .m_rdata(m_rdata),
    .data_ready(data_ready),
    .s_rvalid(s_rvalid),
    .s_rready(s_rready),
    .s_r(s_r)
  );

endmodule

`default_nettype wire

// File: testbench/tb_axi_b2s_rd.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_b2s_rd;

  localparam logic [31:0] seed = 32'hbd31_697c;
  localparam logic [31:0] data_mask = 32'h5a5a_0000;
  localparam int burst_timeout = 2000;
  localparam int hold_cycles = 60;

  logic clk;
  logic reset;
  logic s_arvalid;
  logic s_arready;
  b2s_pkg::ar_cmd_t s_ar;
  logic m_arvalid;
  logic m_arready;
  logic [b2s_pkg::addr_w-1:0] m_araddr;
  logic m_rvalid;
  logic [b2s_pkg::data_w-1:0] m_rdata;
  logic s_rvalid;
  logic s_rready;
  b2s_pkg::r_beat_t s_r;

  logic ar_random; // master stalls m_arready at random while set
  logic [31:0] test_rng;
  logic [31:0] model_rng;
  logic [31:0] addr_q[$];
  int hs_count;

  axi_b2s_rd axi_b2s_rd_i (
    .clk(clk),
    .reset(reset),
    .s_arvalid(s_arvalid),
    .s_arready(s_arready),
    .s_ar(s_ar),
    .m_arvalid(m_arvalid),
    .m_arready(m_arready),
    .m_araddr(m_araddr),
    .m_rvalid(m_rvalid),
    .m_rdata(m_rdata),
    .s_rvalid(s_rvalid),
    .s_rready(s_rready),
    .s_r(s_r)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // master memory returns each beat two cycles after its address is taken, in order
  initial begin : master_model
    logic [1:0] ret_pipe;
    logic hs;
    m_arready = 1'b0;
    m_rvalid = 1'b0;
    m_rdata = '0;
    model_rng = seed;
    hs_count = 0;
    ret_pipe = 2'b00;
    forever begin
      @(negedge clk);
      m_rvalid = ret_pipe[1];
      if (ret_pipe[1]) begin
        m_rdata = addr_q.pop_front() ^ data_mask;
      end else begin
        m_rdata = '0;
      end
      ret_pipe[1] = ret_pipe[0];
      if (ar_random) begin
        model_rng = xorshift(model_rng);
        m_arready = model_rng[0];
      end else begin
        m_arready = 1'b1;
      end
      hs = (m_arvalid === 1'b1) && m_arready; // handshake on the coming rising edge
      ret_pipe[0] = hs;
      if (hs) begin
        addr_q.push_back(m_araddr);
        hs_count++;
      end
    end
  end

  task automatic fail_now();
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s: got %h, expected %h", $time, what, actual, expected);
      fail_now();
    end
  endtask

  // mode 0 keeps s_rready high, 1 holds it low for a while, 2 toggles it at random
  task automatic send_burst(input logic [31:0] addr, input int len, input logic [3:0] id,
                            input int mode);
    int beats;
    int acks;
    int cycles;
    int hs_start;
    logic [31:0] exp_addr;
    beats = 0;
    acks = 0;
    cycles = 0;
    hs_start = hs_count;
    s_ar.addr = addr;
    s_ar.len = 8'(len);
    s_ar.id = id;
    s_arvalid = 1'b1;
    while (beats <= len || acks == 0) begin
      if (mode == 1) begin
        s_rready = (cycles >= hold_cycles);
      end else if (mode == 2) begin
        test_rng = xorshift(test_rng);
        s_rready = test_rng[0] | test_rng[1];
      end else begin
        s_rready = 1'b1;
      end
      if (mode == 1 && !s_rready) begin
        check(32'((hs_count - hs_start) <= b2s_pkg::fifo_depth), 32'd1,
              "outstanding beats within fifo depth");
      end
      if (s_arready === 1'b1) begin
        acks++;
      end
      if (s_rvalid === 1'b1 && s_rready) begin
        exp_addr = addr + 32'(beats * b2s_pkg::beat_bytes);
        check(s_r.data, exp_addr ^ data_mask, "beat data");
        check(32'(s_r.id), 32'(id), "beat id");
        check(32'(s_r.last), 32'(beats == len), "beat last flag");
        beats++;
      end
      @(negedge clk);
      if (acks > 0) begin
        s_arvalid = 1'b0;
      end
      cycles++;
      if (cycles > burst_timeout) begin
        $display("timeout: burst at %h did not finish, %0d beats seen", addr, beats);
        fail_now();
      end
    end
    check(32'(acks), 32'd1, "s_arready pulses per burst");
    check(32'(hs_count - hs_start), 32'(len + 1), "m_ar handshakes per burst");
  endtask

  task automatic check_reset_outputs();
    check(32'(s_arready), 32'd0, "s_arready after reset");
    check(32'(m_arvalid), 32'd0, "m_arvalid after reset");
    check(32'(s_rvalid), 32'd0, "s_rvalid after reset");
  endtask

  task automatic single_beat_burst();
    send_burst(32'h0000_1000, 0, 4'h3, 0);
  endtask

  task automatic four_beat_burst();
    send_burst(32'h0000_2040, 3, 4'ha, 0);
  endtask

  task automatic back_pressure_burst();
    send_burst(32'h0001_0000, 15, 4'h5, 1);
  endtask

  task automatic random_bursts();
    logic [31:0] addr;
    logic [3:0] id;
    int len;
    ar_random = 1'b1;
    for (int n = 0; n < 20; n++) begin
      test_rng = xorshift(test_rng);
      addr = {test_rng[31:2], 2'b00};
      test_rng = xorshift(test_rng);
      len = int'(test_rng[2:0]);
      id = test_rng[7:4];
      send_burst(addr, len, id, 2);
    end
    ar_random = 1'b0;
  endtask

  initial begin
    reset = 1'b1;
    s_arvalid = 1'b0;
    s_ar = '0;
    s_rready = 1'b0;
    ar_random = 1'b0;
    test_rng = seed;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_reset_outputs();
    single_beat_burst();
    four_beat_burst();
    back_pressure_burst();
    random_bursts();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
logic/b2s_pkg.sv
logic/beat_fifo.sv
logic/rd_cmd_fsm.sv
logic/burst_addr_gen.sv
logic/rd_resp_path.sv
logic/axi_b2s_rd.sv
testbench/tb_axi_b2s_rd.sv

// File: Makefile
TOP = tb_axi_b2s_rd

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
